//--- design/hazard_consts.svh
// Hazard unit constants
// Register index width and number of controlled pipeline registers

`ifndef HAZARD_CONSTS_SVH
`define HAZARD_CONSTS_SVH

// Register index width, x0..x31
`define HZ_REG_ADDR_W 5

// Pipeline registers under control
// PC, IF/DEC, DEC/EX, EX/MEM, MEM/WB
`define HZ_STAGE_REGS 5

`endif

//--- design/hazard_pkg.sv
// Hazard unit types
// Stage control codes, branch condition, memory control and sync FSM states
`default_nettype none

package hazard_pkg;

	// Control code for one pipeline register
	typedef enum logic [1:0] {
		ENABLE = 2'b00,
		STALL  = 2'b01,
		FLUSH  = 2'b10
	} hazard_ctrl_e;

	// Branch condition from execute
	typedef enum logic [1:0] {
		NO_JUMP   = 2'b00,
		BRANCH_NT = 2'b01,
		JUMP      = 2'b10
	} if_ctrl_e;

	// Access direction of the memory stage
	typedef enum logic {
		READ  = 1'b0,
		WRITE = 1'b1
	} mem_rw_e;

	// Memory control of the instruction in the memory stage
	typedef struct packed {
		logic    mem_en;
		mem_rw_e wr;
	} mem_ctrl_t;

	// Memory sync FSM states
	typedef enum logic [1:0] {
		ISSUE_REQ  = 2'b00,
		INSTR_BUSY = 2'b01,
		DATA_BUSY  = 2'b10,
		IDLE       = 2'b11
	} sync_state_e;

endpackage

`default_nettype wire

//--- design/mem_sync_if.sv
// Memory sync bundle
// Request, freeze and window levels from the sync FSM to the stage merger
`timescale 1ns/10ps
`default_nettype none

interface mem_sync_if;

	// Memory request levels
	logic instr_req;
	logic data_req;
	// Stall every pipeline register
	logic freeze;
	// Which hazard actions the current state allows
	logic jump_window;
	logic load_window;

	// Producer side
	modport fsm (
		output instr_req, data_req, freeze, jump_window, load_window
	);

	// Consumer side, requests leave through the top level instead
	modport merge (
		input freeze, jump_window, load_window
	);

endinterface

`default_nettype wire

//--- design/mem_sync_fsm.sv
// Memory sync FSM
// Follows instruction and data memory busy levels, drives requests and pipeline freeze
`timescale 1ns/10ps
`default_nettype none

module mem_sync_fsm (
	input  logic        CLK,
	input  logic        RSTn,
	input  logic        instr_busy,
	input  logic        data_busy,
	mem_sync_if.fsm     sync
);

	hazard_pkg::sync_state_e state;
	hazard_pkg::sync_state_e state_nxt;

	// Either memory still working
	logic either_busy;
	logic both_busy;

	assign either_busy = instr_busy | data_busy;
	assign both_busy   = instr_busy & data_busy;

	// State register
	always_ff @(posedge CLK) begin
		if (!RSTn) begin
			state <= hazard_pkg::ISSUE_REQ;
		end else begin
			state <= state_nxt;
		end
	end

	// Next state
	always_comb begin
		state_nxt = state;
		case (state)
			hazard_pkg::ISSUE_REQ, hazard_pkg::IDLE: begin
				// Same exits from both states
				if (!either_busy) begin
					state_nxt = hazard_pkg::ISSUE_REQ;
				end else if (both_busy) begin
					state_nxt = hazard_pkg::IDLE;
				end else if (instr_busy) begin
					state_nxt = hazard_pkg::INSTR_BUSY;
				end else begin
					state_nxt = hazard_pkg::DATA_BUSY;
				end
				// IDLE with nothing busy goes back to issuing
			end
			hazard_pkg::INSTR_BUSY: begin
				// Wait for fetch to finish
				if (!instr_busy) begin
					state_nxt = hazard_pkg::ISSUE_REQ;
				end
			end
			hazard_pkg::DATA_BUSY: begin
				// Wait for load/store to finish
				if (!data_busy) begin
					state_nxt = hazard_pkg::ISSUE_REQ;
				end
			end
			default: begin
				state_nxt = hazard_pkg::ISSUE_REQ;
			end
		endcase
	end

	// Mealy outputs
	always_comb begin
		// Defaults: requests out, nothing frozen, no windows
		sync.instr_req   = 1'b1;
		sync.data_req    = 1'b1;
		sync.freeze      = 1'b0;
		sync.jump_window = 1'b0;
		sync.load_window = 1'b0;
		case (state)
			hazard_pkg::ISSUE_REQ: begin
				// Only a busy fetch freezes here
				sync.freeze      = instr_busy;
				sync.jump_window = 1'b1;
				sync.load_window = 1'b1;
			end
			hazard_pkg::INSTR_BUSY: begin
				sync.freeze      = instr_busy;
				sync.instr_req   = ~instr_busy;
				sync.data_req    = ~instr_busy;
				// Jump flush allowed once fetch is back
				sync.jump_window = ~instr_busy;
			end
			hazard_pkg::DATA_BUSY: begin
				// No new fetch until the data access completes
				sync.freeze    = data_busy;
				sync.instr_req = 1'b0;
				sync.data_req  = ~data_busy;
			end
			hazard_pkg::IDLE: begin
				sync.freeze    = either_busy;
				sync.instr_req = ~either_busy;
				sync.data_req  = ~either_busy;
			end
			default: begin
				sync.freeze = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- design/hazard_detect.sv
// Hazard detector
// Finds load-use data hazards and taken jumps in the instruction flow
`timescale 1ns/10ps
`default_nettype none
`include "hazard_consts.svh"

module hazard_detect (
	input  hazard_pkg::mem_ctrl_t          mem_ctrl,
	input  hazard_pkg::if_ctrl_e           branch_cond,
	input  logic [`HZ_REG_ADDR_W-1:0]      ex_mem_rd,
	input  logic [`HZ_REG_ADDR_W-1:0]      dec_ex_rs1,
	input  logic [`HZ_REG_ADDR_W-1:0]      dec_ex_rs2,
	output logic                           load_use,
	output logic                           jump
);

	// Memory stage holds a load
	logic is_load;
	// Load destination hits a source operand
	logic rs1_hit;
	logic rs2_hit;

	assign is_load = mem_ctrl.mem_en && (mem_ctrl.wr == hazard_pkg::READ);

	// Compare against both sources of the instruction in execute
	assign rs1_hit = (ex_mem_rd == dec_ex_rs1);
	assign rs2_hit = (ex_mem_rd == dec_ex_rs2);

	// Dependent instruction must wait one cycle for the load data
	assign load_use = is_load && (rs1_hit || rs2_hit);

	// Taken branch or unconditional jump
	// Not-taken branch needs no action
	assign jump = (branch_cond == hazard_pkg::JUMP);

endmodule

`default_nettype wire

//--- design/stage_ctrl_merge.sv
// Stage control merger
// Fixed priority of freeze, load-use stall and jump flush into five register codes
`timescale 1ns/10ps
`default_nettype none

module stage_ctrl_merge (
	mem_sync_if.merge                 sync,
	input  logic                      load_use,
	input  logic                      jump,
	output hazard_pkg::hazard_ctrl_e  pc_ctrl,
	output hazard_pkg::hazard_ctrl_e  if_dec_ctrl,
	output hazard_pkg::hazard_ctrl_e  dec_ex_ctrl,
	output hazard_pkg::hazard_ctrl_e  ex_mem_ctrl,
	output hazard_pkg::hazard_ctrl_e  mem_wb_ctrl
);

	// Requests that may act in the current state
	logic load_act;
	logic jump_act;

	assign load_act = load_use & sync.load_window;
	assign jump_act = jump & sync.jump_window;

	always_comb begin
		// Normal flow
		pc_ctrl     = hazard_pkg::ENABLE;
		if_dec_ctrl = hazard_pkg::ENABLE;
		dec_ex_ctrl = hazard_pkg::ENABLE;
		ex_mem_ctrl = hazard_pkg::ENABLE;
		mem_wb_ctrl = hazard_pkg::ENABLE;

		if (sync.freeze) begin
			// Memory not ready, hold the whole pipeline
			pc_ctrl     = hazard_pkg::STALL;
			if_dec_ctrl = hazard_pkg::STALL;
			dec_ex_ctrl = hazard_pkg::STALL;
			ex_mem_ctrl = hazard_pkg::STALL;
			mem_wb_ctrl = hazard_pkg::STALL;
		end else if (load_act) begin
			// Hold fetch and decode
			pc_ctrl     = hazard_pkg::STALL;
			if_dec_ctrl = hazard_pkg::STALL;
			// Bubble into execute while the load completes
			dec_ex_ctrl = hazard_pkg::FLUSH;
		end else if (jump_act) begin
			// Drop the instruction fetched after the jump
			if_dec_ctrl = hazard_pkg::FLUSH;
		end
	end

endmodule

`default_nettype wire

//--- design/hazard_unit.sv
// Hazard unit top level
// Memory sync FSM, hazard detector and stage merger wired to plain ports
`timescale 1ns/10ps
`default_nettype none
`include "hazard_consts.svh"

module hazard_unit (
	input  logic                          CLK,
	input  logic                          RSTn,
	// Memory busy levels
	input  logic                          instr_busy,
	input  logic                          data_busy,
	// Instruction flow
	input  hazard_pkg::mem_ctrl_t         mem_ctrl,
	input  hazard_pkg::if_ctrl_e          branch_cond,
	input  logic [`HZ_REG_ADDR_W-1:0]     ex_mem_rd,
	input  logic [`HZ_REG_ADDR_W-1:0]     dec_ex_rs1,
	input  logic [`HZ_REG_ADDR_W-1:0]     dec_ex_rs2,
	// Memory requests
	output logic                          instr_req,
	output logic                          data_req,
	// Pipeline register codes
	output hazard_pkg::hazard_ctrl_e      pc_ctrl,
	output hazard_pkg::hazard_ctrl_e      if_dec_ctrl,
	output hazard_pkg::hazard_ctrl_e      dec_ex_ctrl,
	output hazard_pkg::hazard_ctrl_e      ex_mem_ctrl,
	output hazard_pkg::hazard_ctrl_e      mem_wb_ctrl
);

	// Detector results
	logic load_use;
	logic jump;

	// FSM to merger bundle
	mem_sync_if sync ();

	mem_sync_fsm i_mem_sync_fsm (
		.CLK        (CLK),
		.RSTn       (RSTn),
		.instr_busy (instr_busy),
		.data_busy  (data_busy),
		.sync       (sync.fsm)
	);

	hazard_detect i_hazard_detect (
		.mem_ctrl    (mem_ctrl),
		.branch_cond (branch_cond),
		.ex_mem_rd   (ex_mem_rd),
		.dec_ex_rs1  (dec_ex_rs1),
		.dec_ex_rs2  (dec_ex_rs2),
		.load_use    (load_use),
		.jump        (jump)
	);

	stage_ctrl_merge i_stage_ctrl_merge (
		.sync        (sync.merge),
		.load_use    (load_use),
		.jump        (jump),
		.pc_ctrl     (pc_ctrl),
		.if_dec_ctrl (if_dec_ctrl),
		.dec_ex_ctrl (dec_ex_ctrl),
		.ex_mem_ctrl (ex_mem_ctrl),
		.mem_wb_ctrl (mem_wb_ctrl)
	);

	// Requests go straight out to the fetcher and the LSU
	assign instr_req = sync.instr_req;
	assign data_req  = sync.data_req;

endmodule

`default_nettype wire

//--- bench/tb_hazard_unit.sv
// Hazard unit testbench
// Reference model of the sync FSM and merge priority with concurrent assertions
`timescale 1ns/10ps
`default_nettype none
`include "hazard_consts.svh"

module tb_hazard_unit;

	// Register positions in the code arrays
	localparam int PC_R     = 0;
	localparam int IF_DEC_R = 1;
	localparam int DEC_EX_R = 2;

	// Worst-case test lengths in cycles
	localparam int RST_CYCLES  = 5;
	localparam int T1_LEN      = 4;
	localparam int T2_LEN      = 11;
	localparam int T3_LEN      = 11;
	localparam int T4_TRIALS   = 8;
	localparam int T4_LEN      = T4_TRIALS * 13;
	localparam int T5_LEN      = 64;
	localparam int REPORT_LEN  = 5;
	localparam int CYCLE_LIMIT = RST_CYCLES + T1_LEN + T2_LEN + T3_LEN + T4_LEN + T5_LEN
		+ REPORT_LEN + 50;

	logic CLK;
	logic RSTn;
	logic instr_busy;
	logic data_busy;
	hazard_pkg::mem_ctrl_t mem_ctrl;
	hazard_pkg::if_ctrl_e branch_cond;
	logic [`HZ_REG_ADDR_W-1:0] ex_mem_rd;
	logic [`HZ_REG_ADDR_W-1:0] dec_ex_rs1;
	logic [`HZ_REG_ADDR_W-1:0] dec_ex_rs2;
	logic instr_req;
	logic data_req;
	hazard_pkg::hazard_ctrl_e pc_ctrl;
	hazard_pkg::hazard_ctrl_e if_dec_ctrl;
	hazard_pkg::hazard_ctrl_e dec_ex_ctrl;
	hazard_pkg::hazard_ctrl_e ex_mem_ctrl;
	hazard_pkg::hazard_ctrl_e mem_wb_ctrl;

	// DUT codes in register order
	hazard_pkg::hazard_ctrl_e dut_code [`HZ_STAGE_REGS];

	// Reference model
	hazard_pkg::sync_state_e model_state;
	logic exp_instr_req;
	logic exp_data_req;
	logic exp_freeze;
	logic exp_jump_win;
	logic exp_load_win;
	logic model_load_use;
	logic model_jump;
	hazard_pkg::hazard_ctrl_e exp_code [`HZ_STAGE_REGS];

	// Bookkeeping
	integer seed = 32'h849c;
	int err_cnt = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;
	int cycle_cnt = 0;
	int errs_at_start;

	hazard_unit i_hazard_unit (
		.CLK         (CLK),
		.RSTn        (RSTn),
		.instr_busy  (instr_busy),
		.data_busy   (data_busy),
		.mem_ctrl    (mem_ctrl),
		.branch_cond (branch_cond),
		.ex_mem_rd   (ex_mem_rd),
		.dec_ex_rs1  (dec_ex_rs1),
		.dec_ex_rs2  (dec_ex_rs2),
		.instr_req   (instr_req),
		.data_req    (data_req),
		.pc_ctrl     (pc_ctrl),
		.if_dec_ctrl (if_dec_ctrl),
		.dec_ex_ctrl (dec_ex_ctrl),
		.ex_mem_ctrl (ex_mem_ctrl),
		.mem_wb_ctrl (mem_wb_ctrl)
	);

	assign dut_code[0] = pc_ctrl;
	assign dut_code[1] = if_dec_ctrl;
	assign dut_code[2] = dec_ex_ctrl;
	assign dut_code[3] = ex_mem_ctrl;
	assign dut_code[4] = mem_wb_ctrl;

	// 100 ns clock
	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	// Next model state from the busy levels of this cycle
	function automatic hazard_pkg::sync_state_e next_sync_state(
		input hazard_pkg::sync_state_e cur,
		input logic ib,
		input logic db
	);
		if (cur == hazard_pkg::INSTR_BUSY) begin
			return ib ? hazard_pkg::INSTR_BUSY : hazard_pkg::ISSUE_REQ;
		end
		if (cur == hazard_pkg::DATA_BUSY) begin
			return db ? hazard_pkg::DATA_BUSY : hazard_pkg::ISSUE_REQ;
		end
		// ISSUE_REQ and IDLE leave the same way
		if (ib && db) begin
			return hazard_pkg::IDLE;
		end
		if (ib) begin
			return hazard_pkg::INSTR_BUSY;
		end
		if (db) begin
			return hazard_pkg::DATA_BUSY;
		end
		return hazard_pkg::ISSUE_REQ;
	endfunction

	always @(posedge CLK) begin
		if (!RSTn) begin
			model_state <= hazard_pkg::ISSUE_REQ;
		end else begin
			model_state <= next_sync_state(model_state, instr_busy, data_busy);
		end
	end

	// Expected levels per state table
	always_comb begin
		exp_jump_win = 1'b0;
		exp_load_win = 1'b0;
		case (model_state)
			hazard_pkg::ISSUE_REQ: begin
				exp_freeze    = instr_busy;
				exp_instr_req = 1'b1;
				exp_data_req  = 1'b1;
				exp_jump_win  = 1'b1;
				exp_load_win  = 1'b1;
			end
			hazard_pkg::INSTR_BUSY: begin
				exp_freeze    = instr_busy;
				exp_instr_req = !instr_busy;
				exp_data_req  = !instr_busy;
				exp_jump_win  = !instr_busy;
			end
			hazard_pkg::DATA_BUSY: begin
				exp_freeze    = data_busy;
				exp_instr_req = 1'b0;
				exp_data_req  = !data_busy;
			end
			default: begin
				// IDLE frozen while anything is busy
				exp_freeze    = instr_busy || data_busy;
				exp_instr_req = !exp_freeze;
				exp_data_req  = !exp_freeze;
			end
		endcase
	end

	// Detector rules and merge priority
	always_comb begin
		model_load_use = mem_ctrl.mem_en && (mem_ctrl.wr == hazard_pkg::READ)
			&& ((ex_mem_rd == dec_ex_rs1) || (ex_mem_rd == dec_ex_rs2));
		model_jump = (branch_cond == hazard_pkg::JUMP);
		for (int k = 0; k < `HZ_STAGE_REGS; k++) begin
			exp_code[k] = exp_freeze ? hazard_pkg::STALL : hazard_pkg::ENABLE;
		end
		if (!exp_freeze && model_load_use && exp_load_win) begin
			exp_code[PC_R]     = hazard_pkg::STALL;
			exp_code[IF_DEC_R] = hazard_pkg::STALL;
			exp_code[DEC_EX_R] = hazard_pkg::FLUSH;
		end else if (!exp_freeze && model_jump && exp_jump_win) begin
			exp_code[IF_DEC_R] = hazard_pkg::FLUSH;
		end
	end

	// Request levels against the model
	instr_req_ok: assert property (@(posedge CLK) disable iff (!RSTn) instr_req == exp_instr_req)
	else begin
		err_cnt++;
		$display("ERROR at %0t ns: instr_req is %b, expected %b", $time,
			$sampled(instr_req), $sampled(exp_instr_req));
	end

	data_req_ok: assert property (@(posedge CLK) disable iff (!RSTn) data_req == exp_data_req)
	else begin
		err_cnt++;
		$display("ERROR at %0t ns: data_req is %b, expected %b", $time,
			$sampled(data_req), $sampled(exp_data_req));
	end

	// One check per pipeline register
	genvar g;
	generate
		for (g = 0; g < `HZ_STAGE_REGS; g++) begin : g_code_chk
			code_ok: assert property (@(posedge CLK) disable iff (!RSTn)
				dut_code[g] == exp_code[g])
			else begin
				err_cnt++;
				$display("ERROR at %0t ns: register %0d code is %0d, expected %0d", $time, g,
					$sampled(dut_code[g]), $sampled(exp_code[g]));
			end
		end
	endgenerate

	// No fetch request anywhere in DATA_BUSY
	no_fetch_in_data_busy: assert property (@(posedge CLK) disable iff (!RSTn)
		(model_state == hazard_pkg::DATA_BUSY) |-> !instr_req)
	else begin
		err_cnt++;
		$display("ERROR at %0t ns: instr_req high in DATA_BUSY", $time);
	end

	// Frozen pipeline never flushes
	no_flush_when_frozen: assert property (@(posedge CLK) disable iff (!RSTn)
		exp_freeze |-> (if_dec_ctrl == hazard_pkg::STALL && dec_ex_ctrl == hazard_pkg::STALL))
	else begin
		err_cnt++;
		$display("ERROR at %0t ns: pipeline not fully stalled while frozen", $time);
	end

	// Load-use wins over a jump in the same cycle
	load_beats_jump: assert property (@(posedge CLK) disable iff (!RSTn)
		(!exp_freeze && exp_load_win && model_load_use && model_jump)
		|-> (if_dec_ctrl == hazard_pkg::STALL))
	else begin
		err_cnt++;
		$display("ERROR at %0t ns: jump flush taken over a load-use stall", $time);
	end

	// Run limit
	always @(posedge CLK) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
			$display("TESTS FAILED");
			$finish;
		end
	end

	task automatic quiet_inputs;
		instr_busy      = 1'b0;
		data_busy       = 1'b0;
		mem_ctrl.mem_en = 1'b0;
		mem_ctrl.wr     = hazard_pkg::READ;
		branch_cond     = hazard_pkg::NO_JUMP;
		ex_mem_rd       = '0;
		dec_ex_rs1      = '0;
		dec_ex_rs2      = '0;
	endtask

	// Random load/store and branch
	// Small index range so matches happen often
	task automatic drive_random_flow;
		logic [31:0] r;
		r = $random(seed);
		mem_ctrl.mem_en = r[0];
		mem_ctrl.wr     = r[1] ? hazard_pkg::WRITE : hazard_pkg::READ;
		ex_mem_rd       = {{(`HZ_REG_ADDR_W-2){1'b0}}, r[3:2]};
		dec_ex_rs1      = {{(`HZ_REG_ADDR_W-2){1'b0}}, r[5:4]};
		dec_ex_rs2      = {{(`HZ_REG_ADDR_W-2){1'b0}}, r[7:6]};
		case (r[9:8])
			2'b00:   branch_cond = hazard_pkg::NO_JUMP;
			2'b01:   branch_cond = hazard_pkg::BRANCH_NT;
			default: branch_cond = hazard_pkg::JUMP;
		endcase
	endtask

	task automatic report_test(input string name, input int errs_before);
		@(negedge CLK);
		quiet_inputs();
		if (err_cnt == errs_before) begin
			pass_cnt++;
			$display("%s: ok", name);
		end else begin
			fail_cnt++;
			$display("%s: %0d mismatches", name, err_cnt - errs_before);
		end
	endtask

	// Fetch busy with a jump held through the busy period and the first free cycle
	task automatic instr_busy_test;
		logic [31:0] r;
		int n;
		r = $random(seed);
		n = int'(r[2:0]) + 1;
		for (int i = 0; i < n; i++) begin
			@(negedge CLK);
			instr_busy  = 1'b1;
			branch_cond = hazard_pkg::JUMP;
		end
		@(negedge CLK);
		instr_busy = 1'b0;
		@(negedge CLK);
		branch_cond = hazard_pkg::NO_JUMP;
	endtask

	// Data busy with a load-use hazard present all along
	task automatic data_busy_test;
		logic [31:0] r;
		int n;
		r = $random(seed);
		n = int'(r[2:0]) + 1;
		mem_ctrl.mem_en = 1'b1;
		mem_ctrl.wr     = hazard_pkg::READ;
		ex_mem_rd       = `HZ_REG_ADDR_W'(5);
		dec_ex_rs1      = `HZ_REG_ADDR_W'(5);
		dec_ex_rs2      = `HZ_REG_ADDR_W'(9);
		for (int i = 0; i < n; i++) begin
			@(negedge CLK);
			data_busy = 1'b1;
		end
		// Released but still in DATA_BUSY for one cycle
		@(negedge CLK);
		data_busy = 1'b0;
		@(negedge CLK);
		mem_ctrl.mem_en = 1'b0;
	endtask

	// Both busy then one or neither busy a little longer
	task automatic both_busy_test;
		logic [31:0] r;
		int n_both;
		int n_tail;
		for (int t = 0; t < T4_TRIALS; t++) begin
			r = $random(seed);
			n_both = int'(r[2:0]) + 1;
			n_tail = int'(r[5:4]);
			for (int i = 0; i < n_both; i++) begin
				@(negedge CLK);
				instr_busy = 1'b1;
				data_busy  = 1'b1;
				drive_random_flow();
			end
			for (int i = 0; i < n_tail; i++) begin
				@(negedge CLK);
				instr_busy = r[3];
				data_busy  = !r[3];
				drive_random_flow();
			end
			repeat (2) begin
				@(negedge CLK);
				instr_busy = 1'b0;
				data_busy  = 1'b0;
				drive_random_flow();
			end
		end
	endtask

	task automatic random_flow_test;
		// Load-use and jump together in one cycle
		@(negedge CLK);
		mem_ctrl.mem_en = 1'b1;
		mem_ctrl.wr     = hazard_pkg::READ;
		ex_mem_rd       = `HZ_REG_ADDR_W'(3);
		dec_ex_rs1      = `HZ_REG_ADDR_W'(1);
		dec_ex_rs2      = `HZ_REG_ADDR_W'(3);
		branch_cond     = hazard_pkg::JUMP;
		for (int i = 1; i < T5_LEN; i++) begin
			@(negedge CLK);
			drive_random_flow();
		end
	endtask

	initial begin
		RSTn = 1'b0;
		quiet_inputs();
		repeat (RST_CYCLES) @(negedge CLK);
		RSTn = 1'b1;

		errs_at_start = err_cnt;
		repeat (T1_LEN - 1) @(negedge CLK);
		report_test("reset idle", errs_at_start);

		errs_at_start = err_cnt;
		instr_busy_test();
		report_test("instruction busy", errs_at_start);

		errs_at_start = err_cnt;
		data_busy_test();
		report_test("data busy", errs_at_start);

		errs_at_start = err_cnt;
		both_busy_test();
		report_test("both busy", errs_at_start);

		errs_at_start = err_cnt;
		random_flow_test();
		report_test("random load/store", errs_at_start);

		$display("Tests: %0d ok, %0d with mismatches, %0d errors in total",
			pass_cnt, fail_cnt, err_cnt);
		if (fail_cnt == 0 && err_cnt == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+design
design/hazard_pkg.sv
design/mem_sync_if.sv
design/mem_sync_fsm.sv
design/hazard_detect.sv
design/stage_ctrl_merge.sv
design/hazard_unit.sv
bench/tb_hazard_unit.sv

//--- Makefile
# Verilator build and run of the hazard unit testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_hazard_unit
FILELIST = list.f

OBJ_DIR  = obj_dir
SIM_BIN  = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q '^TESTS PASSED$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
